/* rtl/tdc_pkg.sv */
package tdc_pkg;

  // array geometry
  localparam int num_channels = 4;
  localparam int channel_index_width = 2;

  // one tap per inverter pair of the delay chain
  localparam int chain_taps = 143;

  localparam int coarse_width = 32; // sampling_clk edge count
  localparam int fine_width = 9; // holds up to twice the tap count

  // the conversion counter walks 0 to this value, then results latch
  localparam int conversion_last_step = 145;

  typedef enum logic [1:0] {
    state_idle,
    state_measuring,
    state_converting,
    state_done
  } channel_state_t;

endpackage

/* rtl/tdc_delay_line.sv */
`timescale 1ns/1ps

module tdc_delay_line
  import tdc_pkg::*;
(
  input  logic                  sampling_clk,
  input  logic                  capture_clear_n,
  input  logic                  start_edge,
  input  logic                  stop_edge,
  output logic [chain_taps-1:0] start_taps,
  output logic [chain_taps-1:0] stop_taps,
  output logic                  start_level,
  output logic                  stop_level,
  output logic                  start_seen,
  output logic                  stop_seen
);

  logic [chain_taps-1:0] chain;
  logic [chain_taps-2:0] chain_n;

  assign chain[0] = sampling_clk; // edges of the sampling clock ripple down the chain

  generate
    for (genvar i = 0; i < chain_taps - 1; i++)
    begin : g_tap
      assign chain_n[i] = ~chain[i];
      assign chain[i + 1] = ~chain_n[i];
    end
  endgenerate

  always_ff @(posedge start_edge or negedge capture_clear_n)
  begin
    if (!capture_clear_n)
    begin
      start_seen <= 1'b0;
    end
    else
    begin
      start_seen <= 1'b1;
    end
  end

  always_ff @(posedge stop_edge or negedge capture_clear_n)
  begin
    if (!capture_clear_n)
    begin
      stop_seen <= 1'b0;
    end
    else if (start_seen)
    begin
      stop_seen <= 1'b1; // a stop before any start is ignored
    end
  end

  always_ff @(posedge start_edge or negedge capture_clear_n)
  begin
    if (!capture_clear_n)
    begin
      start_taps <= '0;
      start_level <= 1'b0;
    end
    else if (!start_seen)
    begin
      start_taps <= chain; // only the first start edge counts
      start_level <= sampling_clk;
    end
  end

  always_ff @(posedge stop_edge or negedge capture_clear_n)
  begin
    if (!capture_clear_n)
    begin
      stop_taps <= '0;
      stop_level <= 1'b0;
    end
    else if (start_seen && !stop_seen)
    begin
      stop_taps <= chain;
      stop_level <= sampling_clk;
    end
  end

endmodule

/* rtl/tdc_hit_router.sv */
`timescale 1ns/1ps

module tdc_hit_router
  import tdc_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_internal_logic,
  input  logic                    arm,
  input  logic [num_channels-1:0] channel_enable,
  input  logic                    start_hit,
  input  logic [num_channels-1:0] stop_hit,
  input  logic [num_channels-1:0] channel_done,
  output logic [num_channels-1:0] channel_start,
  output logic [num_channels-1:0] channel_stop
);

  logic [num_channels-1:0] armed;
  logic [num_channels-1:0] arm_request;
  logic [num_channels-1:0] gate_open;

  assign arm_request = {num_channels{arm}} & channel_enable;

  // dropping the enable level closes the gate even on an armed channel
  assign gate_open = armed & channel_enable;

  always_ff @(posedge clk or negedge reset_internal_logic)
  begin
    if (!reset_internal_logic)
    begin
      armed <= '0;
    end
    else
    begin
      armed <= (armed & ~channel_done) | arm_request; // a fresh arm wins over done
    end
  end

  generate
    for (genvar i = 0; i < num_channels; i++)
    begin : g_gate
      assign channel_start[i] = start_hit & gate_open[i]; // shared start fans out
      assign channel_stop[i] = stop_hit[i] & gate_open[i];
    end
  endgenerate

endmodule

/* rtl/tdc_channel.sv */
`timescale 1ns/1ps

module tdc_channel
  import tdc_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_internal_logic,
  input  logic                    sampling_clk,
  input  logic                    start_edge,
  input  logic                    stop_edge,
  output logic                    busy,
  output logic                    done,
  output logic [coarse_width-1:0] coarse,
  output logic [fine_width-1:0]   fine
);

  channel_state_t state;

  logic [chain_taps-1:0]   start_taps;
  logic [chain_taps-1:0]   stop_taps;
  logic                    start_level;
  logic                    stop_level;
  logic                    start_seen;
  logic                    stop_seen;
  logic                    capture_clear_n;
  logic [1:0]              seen_meta;
  logic [1:0]              seen_sync;
  logic [coarse_width-1:0] coarse_count;
  logic [fine_width-1:0]   step_count;
  logic [chain_taps-1:0]   xor_shift;
  logic [chain_taps-1:0]   start_shift;
  logic [chain_taps-1:0]   stop_shift;
  logic [fine_width-1:0]   fine_count;
  logic [fine_width-1:0]   start_ones;
  logic [fine_width-1:0]   stop_ones;
  logic [fine_width-1:0]   positions_sum;
  logic                    begin_conversion;
  logic                    fold_needed;
  logic                    coarse_adjust;

  assign capture_clear_n = reset_internal_logic & ~done; // done doubles as the re-arm clear

  tdc_delay_line i_delay_line (
    .sampling_clk    (sampling_clk),
    .capture_clear_n (capture_clear_n),
    .start_edge      (start_edge),
    .stop_edge       (stop_edge),
    .start_taps      (start_taps),
    .stop_taps       (stop_taps),
    .start_level     (start_level),
    .stop_level      (stop_level),
    .start_seen      (start_seen),
    .stop_seen       (stop_seen)
  );

  always_ff @(posedge sampling_clk or negedge capture_clear_n)
  begin
    if (!capture_clear_n)
    begin
      coarse_count <= '0;
    end
    else if (start_seen != stop_seen)
    begin
      coarse_count <= coarse_count + 1'b1; // runs only between start and stop
    end
  end

  // the seen flags come from the hit domain
  always_ff @(posedge clk or negedge reset_internal_logic)
  begin
    if (!reset_internal_logic)
    begin
      seen_meta <= 2'b00;
      seen_sync <= 2'b00;
    end
    else
    begin
      seen_meta <= {stop_seen, start_seen};
      seen_sync <= seen_meta;
    end
  end

  assign begin_conversion = seen_sync[1] &&
                            ((state == state_idle) || (state == state_measuring));
  assign positions_sum = start_ones + stop_ones;
  assign fold_needed = (start_level != stop_level) &&
                       (positions_sum > fine_width'(chain_taps));
  assign coarse_adjust = !start_level && stop_level && (coarse_count == coarse_width'(1));
  assign busy = start_seen | stop_seen | (state == state_converting);

  always_ff @(posedge clk or negedge reset_internal_logic)
  begin
    if (!reset_internal_logic)
    begin
      state <= state_idle;
      step_count <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        state_idle, state_measuring:
        begin
          if (begin_conversion)
          begin
            state <= state_converting;
            step_count <= fine_width'(1); // this edge performs step 0
          end
          else if (seen_sync[0])
          begin
            state <= state_measuring;
          end
        end
        state_converting:
        begin
          if (step_count == fine_width'(conversion_last_step))
          begin
            state <= state_done;
            step_count <= '0;
            done <= 1'b1;
          end
          else
          begin
            step_count <= step_count + 1'b1;
          end
        end
        state_done:
        begin
          if (!seen_sync[1])
          begin
            state <= state_idle; // wait until the cleared stop flag has crossed over
          end
        end
        default:
        begin
          state <= state_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (begin_conversion)
    begin
      xor_shift <= start_taps ^ stop_taps;
      start_shift <= start_taps;
      stop_shift <= stop_taps;
      fine_count <= '0;
      start_ones <= '0;
      stop_ones <= '0;
    end
    else if (state == state_converting)
    begin
      xor_shift <= xor_shift >> 1;
      start_shift <= start_shift >> 1;
      stop_shift <= stop_shift >> 1;
      start_ones <= start_ones + fine_width'(start_shift[0]);
      stop_ones <= stop_ones + fine_width'(stop_shift[0]);
      if ((step_count == fine_width'(conversion_last_step - 1)) && fold_needed)
      begin
        fine_count <= fine_width'(2 * chain_taps) - fine_count; // edge crossed the chain end
      end
      else
      begin
        fine_count <= fine_count + fine_width'(xor_shift[0]);
      end
      if (step_count == fine_width'(conversion_last_step))
      begin
        fine <= fine_count;
        coarse <= coarse_adjust ? coarse_count - 1'b1 : coarse_count;
      end
    end
  end

endmodule

/* rtl/tdc_result_collector.sv */
`timescale 1ns/1ps

module tdc_result_collector
  import tdc_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 reset_internal_logic,
  input  logic [num_channels-1:0]              channel_done,
  input  logic [num_channels*coarse_width-1:0] channel_coarse,
  input  logic [num_channels*fine_width-1:0]   channel_fine,
  output logic                                 result_valid,
  output logic [channel_index_width-1:0]       result_channel,
  output logic [coarse_width-1:0]              result_coarse,
  output logic [fine_width-1:0]                result_fine
);

  logic [num_channels-1:0]        pending;
  logic [coarse_width-1:0]        held_coarse [num_channels];
  logic [fine_width-1:0]          held_fine [num_channels];
  logic                           pick_valid;
  logic [channel_index_width-1:0] pick_index;
  logic [num_channels-1:0]        pick_mask;

  // scan downwards so the lowest pending channel is left in pick_index
  always_comb
  begin
    pick_valid = 1'b0;
    pick_index = '0;
    for (int i = num_channels - 1; i >= 0; i--)
    begin
      if (pending[i])
      begin
        pick_valid = 1'b1;
        pick_index = channel_index_width'(i);
      end
    end
  end

  assign pick_mask = pick_valid ? (num_channels'(1) << pick_index) : '0;

  always_ff @(posedge clk or negedge reset_internal_logic)
  begin
    if (!reset_internal_logic)
    begin
      pending <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      pending <= (pending & ~pick_mask) | channel_done;
      result_valid <= pick_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < num_channels; i++)
    begin
      if (channel_done[i])
      begin
        held_coarse[i] <= channel_coarse[i*coarse_width +: coarse_width];
        held_fine[i] <= channel_fine[i*fine_width +: fine_width];
      end
    end
    if (pick_valid)
    begin
      result_channel <= pick_index;
      result_coarse <= held_coarse[pick_index];
      result_fine <= held_fine[pick_index];
    end
  end

endmodule

/* rtl/tdc_array_top.sv */
`timescale 1ns/1ps

module tdc_array_top
  import tdc_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset_internal_logic,
  input  logic                           sampling_clk,
  input  logic                           start_hit,
  input  logic [num_channels-1:0]        stop_hit,
  input  logic [num_channels-1:0]        channel_enable,
  input  logic                           arm,
  output logic [num_channels-1:0]        channel_busy,
  output logic                           result_valid,
  output logic [channel_index_width-1:0] result_channel,
  output logic [coarse_width-1:0]        result_coarse,
  output logic [fine_width-1:0]          result_fine
);

  logic [num_channels-1:0]              channel_start;
  logic [num_channels-1:0]              channel_stop;
  logic [num_channels-1:0]              channel_done;
  logic [num_channels*coarse_width-1:0] channel_coarse;
  logic [num_channels*fine_width-1:0]   channel_fine;

  tdc_hit_router i_hit_router (
    .clk                  (clk),
    .reset_internal_logic (reset_internal_logic),
    .arm                  (arm),
    .channel_enable       (channel_enable),
    .start_hit            (start_hit),
    .stop_hit             (stop_hit),
    .channel_done         (channel_done),
    .channel_start        (channel_start),
    .channel_stop         (channel_stop)
  );

  generate
    for (genvar i = 0; i < num_channels; i++)
    begin : g_channel
      tdc_channel i_channel (
        .clk                  (clk),
        .reset_internal_logic (reset_internal_logic),
        .sampling_clk         (sampling_clk),
        .start_edge           (channel_start[i]),
        .stop_edge            (channel_stop[i]),
        .busy                 (channel_busy[i]),
        .done                 (channel_done[i]),
        .coarse               (channel_coarse[i*coarse_width +: coarse_width]),
        .fine                 (channel_fine[i*fine_width +: fine_width])
      );
    end
  endgenerate

  tdc_result_collector i_result_collector (
    .clk                  (clk),
    .reset_internal_logic (reset_internal_logic),
    .channel_done         (channel_done),
    .channel_coarse       (channel_coarse),
    .channel_fine         (channel_fine),
    .result_valid         (result_valid),
    .result_channel       (result_channel),
    .result_coarse        (result_coarse),
    .result_fine          (result_fine)
  );

endmodule

/* verification/tdc_array_tb.sv */
`timescale 1ns/1ps

module tdc_array_tb
  import tdc_pkg::*;
();

  localparam int clk_half = 20;
  localparam int sampling_half = 5;
  localparam int reset_cycles = 16;
  localparam int test_count = 6;
  localparam int cycles_per_test = 400;
  localparam int timeout_cycles = test_count * cycles_per_test;
  localparam int result_wait_cycles = 300;
  localparam int silence_cycles = 40;

  logic                           clk;
  logic                           reset_internal_logic;
  logic                           sampling_clk;
  logic                           start_hit;
  logic [num_channels-1:0]        stop_hit;
  logic [num_channels-1:0]        channel_enable;
  logic                           arm;
  logic [num_channels-1:0]        channel_busy;
  logic                           result_valid;
  logic [channel_index_width-1:0] result_channel;
  logic [coarse_width-1:0]        result_coarse;
  logic [fine_width-1:0]          result_fine;

  logic [coarse_width-1:0] sample_edges; // free-running count of sampling_clk rising edges
  logic [coarse_width-1:0] start_count;
  logic                    start_lvl;
  logic [coarse_width-1:0] stop_count [num_channels];
  logic                    stop_lvl [num_channels];
  logic [num_channels-1:0] quiet_mask;
  logic                    busy_leak;
  int                      value_errors;
  int                      event_errors;
  int                      cycle_count;
  int                      seed;

  tdc_array_top i_dut (
    .clk                  (clk),
    .reset_internal_logic (reset_internal_logic),
    .sampling_clk         (sampling_clk),
    .start_hit            (start_hit),
    .stop_hit             (stop_hit),
    .channel_enable       (channel_enable),
    .arm                  (arm),
    .channel_busy         (channel_busy),
    .result_valid         (result_valid),
    .result_channel       (result_channel),
    .result_coarse        (result_coarse),
    .result_fine          (result_fine)
  );

  initial
  begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  initial
  begin
    sampling_clk = 1'b0;
    forever #sampling_half sampling_clk = ~sampling_clk;
  end

  always @(posedge sampling_clk)
  begin
    sample_edges <= sample_edges + coarse_width'(1);
  end

  always @(negedge clk)
  begin
    if ((channel_busy & quiet_mask) != '0)
    begin
      busy_leak = 1'b1; // a gated channel reacted to a hit
    end
  end

  function automatic logic [coarse_width-1:0] expected_coarse(input int ch);
    logic [coarse_width-1:0] edges;
    edges = stop_count[ch] - start_count;
    if (!start_lvl && stop_lvl[ch] && (edges == coarse_width'(1)))
    begin
      edges = '0; // the single edge is already covered by the fine part
    end
    return edges;
  endfunction

  function automatic logic [fine_width-1:0] expected_fine(input int ch);
    return (start_lvl != stop_lvl[ch]) ? fine_width'(chain_taps) : '0;
  endfunction

  task automatic check_coarse(input logic [coarse_width-1:0] actual,
                              input logic [coarse_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[FAIL] result_coarse: got 0x%08h, expected 0x%08h", actual, expected);
    end
  endtask

  task automatic check_fine(input logic [fine_width-1:0] actual,
                            input logic [fine_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[FAIL] result_fine: got 0x%03h, expected 0x%03h", actual, expected);
    end
  endtask

  task automatic check_channel(input logic [channel_index_width-1:0] actual,
                               input logic [channel_index_width-1:0] expected);
    if (actual !== expected)
    begin
      value_errors++;
      $display("[FAIL] result_channel: got 0x%0h, expected 0x%0h", actual, expected);
    end
  endtask

  task automatic check_result(input int ch);
    check_channel(result_channel, channel_index_width'(ch));
    check_coarse(result_coarse, expected_coarse(ch));
    check_fine(result_fine, expected_fine(ch));
  endtask

  task automatic arm_channels(input logic [num_channels-1:0] mask);
    @(posedge clk);
    #2;
    channel_enable = mask;
    arm = 1'b1;
    @(posedge clk);
    #2;
    arm = 1'b0;
  endtask

  // hits land 2 ns after a sampling_clk edge so the captured level is known
  task automatic fire_start(input logic at_high);
    if (at_high)
    begin
      @(posedge sampling_clk);
    end
    else
    begin
      @(negedge sampling_clk);
    end
    #2;
    start_count = sample_edges;
    start_lvl = sampling_clk;
    start_hit = 1'b1;
    #1;
    start_hit = 1'b0;
  endtask

  task automatic fire_stop(input logic [num_channels-1:0] mask, input int after_edges,
                           input logic at_high);
    repeat (after_edges) @(posedge sampling_clk);
    if (!at_high)
    begin
      @(negedge sampling_clk);
    end
    #2;
    for (int i = 0; i < num_channels; i++)
    begin
      stop_count[i] = sample_edges;
      stop_lvl[i] = sampling_clk;
    end
    stop_hit = mask;
    #1;
    stop_hit = '0;
  endtask

  task automatic wait_result(output logic found);
    int waited;
    found = 1'b0;
    waited = 0;
    while (!found && (waited < result_wait_cycles))
    begin
      @(negedge clk);
      found = result_valid;
      waited++;
    end
    if (!found)
    begin
      event_errors++;
      $display("no result_valid appeared within %0d cycles", result_wait_cycles);
    end
  endtask

  task automatic test_equal_levels();
    logic found;
    $display("test: equal start and stop levels");
    arm_channels(4'b0001);
    fire_start(1'b0);
    fire_stop(4'b0001, 6, 1'b0);
    wait_result(found);
    if (found)
    begin
      check_result(0);
    end
  endtask

  task automatic test_single_edge_correction();
    logic found;
    $display("test: low to high with one sampling edge");
    arm_channels(4'b0010);
    fire_start(1'b0);
    fire_stop(4'b0010, 1, 1'b1);
    wait_result(found);
    if (found)
    begin
      check_result(1);
    end
  endtask

  task automatic test_random_gaps();
    logic found;
    int gap;
    $display("test: low to high with random gaps");
    for (int ch = 2; ch < num_channels; ch++)
    begin
      gap = 2 + int'($unsigned($random(seed)) % 24);
      arm_channels(4'b0001 << ch);
      fire_start(1'b0);
      fire_stop(4'b0001 << ch, gap, 1'b1);
      wait_result(found);
      if (found)
      begin
        check_result(ch);
      end
    end
  endtask

  task automatic test_simultaneous_stops();
    logic found;
    int offsets [num_channels];
    int elapsed;
    $display("test: four channels finishing together");
    offsets = '{3, 8, 18, 28}; // ns after one clk edge, so all stops sync on the same edge
    arm_channels(4'b1111);
    fire_start(1'b1);
    repeat (4) @(posedge clk);
    elapsed = 0;
    for (int i = 0; i < num_channels; i++)
    begin
      #(offsets[i] - elapsed);
      stop_count[i] = sample_edges;
      stop_lvl[i] = sampling_clk;
      stop_hit[i] = 1'b1;
      #1;
      stop_hit[i] = 1'b0;
      elapsed = offsets[i] + 1;
    end
    wait_result(found);
    for (int i = 0; i < num_channels; i++)
    begin
      if (i > 0)
      begin
        @(negedge clk);
        found = result_valid;
        if (!found)
        begin
          event_errors++;
          $display("result for channel %0d did not follow on the next cycle", i);
        end
      end
      if (found)
      begin
        check_result(i);
      end
    end
  endtask

  task automatic test_blocked_channels();
    logic found;
    $display("test: disabled and unarmed channels ignore hits");
    arm_channels(4'b0001);
    @(posedge clk);
    #2;
    channel_enable = 4'b1001; // channel 3 enabled only after the arm pulse
    busy_leak = 1'b0;
    quiet_mask = 4'b1110;
    fire_start(1'b0);
    fire_stop(4'b1111, 5, 1'b0);
    wait_result(found);
    if (found)
    begin
      check_result(0);
    end
    repeat (silence_cycles)
    begin
      @(negedge clk);
      if (result_valid)
      begin
        event_errors++;
        $display("unexpected result_valid from channel %0d", result_channel);
      end
    end
    quiet_mask = '0;
    if (busy_leak)
    begin
      event_errors++;
      $display("a disabled or unarmed channel went busy");
    end
  endtask

  task automatic test_rearm();
    logic found;
    $display("test: second measurement after re-arm");
    arm_channels(4'b0100);
    fire_start(1'b1);
    if (!channel_busy[2])
    begin
      event_errors++;
      $display("channel 2 is not busy after its start hit");
    end
    fire_stop(4'b0100, 3, 1'b1);
    wait_result(found);
    if (found)
    begin
      check_result(2);
    end
    if (channel_busy[2])
    begin
      event_errors++;
      $display("channel 2 is still busy after its result");
    end
    arm_channels(4'b0100);
    fire_start(1'b0);
    fire_stop(4'b0100, 9, 1'b0);
    wait_result(found);
    if (found)
    begin
      check_result(2); // a count left over from the first run would show here
    end
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d clk cycles, the tests did not finish", cycle_count);
    $display("ERRORS FOUND");
    $finish;
  end

  initial
  begin
    reset_internal_logic = 1'b0;
    arm = 1'b0;
    channel_enable = '0;
    start_hit = 1'b0;
    stop_hit = '0;
    sample_edges = '0;
    quiet_mask = '0;
    busy_leak = 1'b0;
    value_errors = 0;
    event_errors = 0;
    seed = 93075;
    repeat (reset_cycles) @(posedge clk);
    #2;
    reset_internal_logic = 1'b1;
    test_equal_levels();
    test_single_edge_correction();
    test_random_gaps();
    test_simultaneous_stops();
    test_blocked_channels();
    test_rearm();
    $display("summary: %0d value errors, %0d other errors", value_errors, event_errors);
    if ((value_errors == 0) && (event_errors == 0))
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* compile.f */
rtl/tdc_pkg.sv
rtl/tdc_delay_line.sv
rtl/tdc_hit_router.sv
rtl/tdc_channel.sv
rtl/tdc_result_collector.sv
rtl/tdc_array_top.sv
verification/tdc_array_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the TDC array testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tdc_array_tb \
  -Mdir obj_dir -o tdc_array_sim \
  || { echo "build failed"; exit 1; }

sim_output="$(./obj_dir/tdc_array_sim)"
echo "$sim_output"
echo "$sim_output" | grep -qx "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
